//--- alu_cluster.f
verilog/alu_pkg.sv
verilog/alu_ifs.sv
verilog/alu_rs_station.sv
verilog/alu_exec_fsm.sv
verilog/alu_shift_counter.sv
verilog/alu_datapath.sv
verilog/alu_cluster.sv
testbench/tb_alu_cluster.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_alu_cluster
RTL_TOP   ?= alu_cluster
FLIST     ?= alu_cluster.f
MDIR      ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
LINT_OPTS ?= --lint-only --timing
PASS_MSG  ?= Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FLIST)

# The run fails unless the pass message shows up in the simulator output.
run: build
	@out="$$(./$(MDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_OPTS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(MDIR)

//--- testbench/tb_alu_cluster.sv
`timescale 1ns/1ns

module tb_alu_cluster;

  localparam int rs_depth     = 4;
  localparam int reset_cycles = 8;
  localparam int drive_dly    = 2;
  localparam int rand_count   = 40;
  localparam int row_count    = 17 + 1 + 4 + (rs_depth + 1) + rand_count;
  localparam int cycle_limit  = row_count * 40 + reset_cycles;

  typedef struct packed {
    alu_pkg::tag_t  target;
    logic [3:0]     op;
    alu_pkg::data_t val1;
    alu_pkg::data_t val2;
    alu_pkg::tag_t  tag1;
    alu_pkg::tag_t  tag2;
    alu_pkg::data_t result;
  } row_t;

  // ======================================================================
  // Directed rows with all operands present
  // ======================================================================

  localparam row_t dir_rows [17] = '{
    '{4'd1,  alu_pkg::op_add,  32'h00000005, 32'h00000007, 4'd0, 4'd0, 32'h0000000c},
    '{4'd2,  alu_pkg::op_addu, 32'hffffffff, 32'h00000001, 4'd0, 4'd0, 32'h00000000},
    '{4'd3,  alu_pkg::op_sub,  32'h00000003, 32'h00000005, 4'd0, 4'd0, 32'hfffffffe},
    '{4'd4,  alu_pkg::op_subu, 32'h00000010, 32'h00000001, 4'd0, 4'd0, 32'h0000000f},
    '{4'd5,  alu_pkg::op_and,  32'hf0f0f0f0, 32'hff00ff00, 4'd0, 4'd0, 32'hf000f000},
    '{4'd6,  alu_pkg::op_or,   32'hf0f0f0f0, 32'h0f0f0000, 4'd0, 4'd0, 32'hfffff0f0},
    '{4'd7,  alu_pkg::op_nor,  32'h0000ffff, 32'h00ff0000, 4'd0, 4'd0, 32'hff000000},
    '{4'd8,  alu_pkg::op_xor,  32'haaaa5555, 32'hffff0000, 4'd0, 4'd0, 32'h55555555},
    '{4'd9,  alu_pkg::op_sll,  32'h00000004, 32'h00000001, 4'd0, 4'd0, 32'h00000010},
    '{4'd10, alu_pkg::op_srl,  32'h0000001f, 32'h80000000, 4'd0, 4'd0, 32'h00000001},
    '{4'd11, alu_pkg::op_sra,  32'h00000008, 32'h80000000, 4'd0, 4'd0, 32'hff800000},
    '{4'd12, alu_pkg::op_ror,  32'h00000004, 32'h12345678, 4'd0, 4'd0, 32'h81234567},
    '{4'd13, alu_pkg::op_sll,  32'h00000020, 32'hdeadbeef, 4'd0, 4'd0, 32'hdeadbeef},
    '{4'd14, alu_pkg::op_seq,  32'h00000007, 32'h00000007, 4'd0, 4'd0, 32'h00000001},
    '{4'd15, alu_pkg::op_slt,  32'hffffffff, 32'h00000001, 4'd0, 4'd0, 32'h00000001},
    '{4'd1,  alu_pkg::op_sltu, 32'hffffffff, 32'h00000001, 4'd0, 4'd0, 32'h00000000},
    '{4'd2,  4'd15,            32'h00000001, 32'h00000002, 4'd0, 4'd0, 32'h00000000}
  };

  logic             rst = 1'b0;
  logic             arst_n;
  alu_pkg::tag_t    disp_target;
  alu_pkg::alu_op_e disp_op;
  alu_pkg::data_t   disp_val1;
  alu_pkg::data_t   disp_val2;
  alu_pkg::tag_t    disp_tag1;
  alu_pkg::tag_t    disp_tag2;
  logic             full;
  logic             ext_cdb_valid;
  alu_pkg::tag_t    ext_cdb_tag;
  alu_pkg::data_t   ext_cdb_value;
  logic             cdb_valid;
  alu_pkg::tag_t    cdb_tag;
  alu_pkg::data_t   cdb_value;
  logic             cdb_ready;

  logic [15:0]      pending;          // One bit per tag in flight.
  alu_pkg::data_t   exp_value [16];
  logic [15:0]      lfsr_state = 16'd71;
  logic             random_ready;
  row_t             rand_rows [rand_count];
  row_t             r;
  int               errors = 0;
  int               checks = 0;
  int               bcast_count = 0;
  int               cycles = 0;
  int               err_mark;
  int               bcast_mark;
  alu_pkg::tag_t    hold_tag;
  alu_pkg::data_t   hold_val;

  alu_cluster #(
    .rs_depth (rs_depth)
  ) i_alu_cluster (
    .rst           (rst),
    .arst_n        (arst_n),
    .disp_target   (disp_target),
    .disp_op       (disp_op),
    .disp_val1     (disp_val1),
    .disp_val2     (disp_val2),
    .disp_tag1     (disp_tag1),
    .disp_tag2     (disp_tag2),
    .full          (full),
    .ext_cdb_valid (ext_cdb_valid),
    .ext_cdb_tag   (ext_cdb_tag),
    .ext_cdb_value (ext_cdb_value),
    .cdb_valid     (cdb_valid),
    .cdb_tag       (cdb_tag),
    .cdb_value     (cdb_value),
    .cdb_ready     (cdb_ready)
  );

  always #20 rst = ~rst;

  // ======================================================================
  // Helpers
  // ======================================================================

  // Taps 16, 14, 13, 11.
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] take_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  function automatic alu_pkg::data_t model_result(logic [3:0] op, alu_pkg::data_t a,
                                                  alu_pkg::data_t b);
    logic [4:0]  amt;
    logic [63:0] rot;
    amt = a[4:0];
    rot = {b, b} >> amt;
    case (alu_pkg::alu_op_e'(op))
      alu_pkg::op_add, alu_pkg::op_addu: return a + b;
      alu_pkg::op_sub, alu_pkg::op_subu: return a - b;
      alu_pkg::op_and:  return a & b;
      alu_pkg::op_or:   return a | b;
      alu_pkg::op_nor:  return ~(a | b);
      alu_pkg::op_xor:  return a ^ b;
      alu_pkg::op_sll:  return b << amt;
      alu_pkg::op_srl:  return b >> amt;
      alu_pkg::op_sra:  return $signed(b) >>> amt;
      alu_pkg::op_ror:  return rot[31:0];
      alu_pkg::op_seq:  return {31'b0, a == b};
      alu_pkg::op_slt:  return {31'b0, $signed(a) < $signed(b)};
      alu_pkg::op_sltu: return {31'b0, a < b};
      default:          return '0;
    endcase
  endfunction

  function automatic row_t make_row(alu_pkg::tag_t t, logic [3:0] op, alu_pkg::data_t v1,
                                    alu_pkg::data_t v2, alu_pkg::tag_t t1,
                                    alu_pkg::tag_t t2, alu_pkg::data_t res);
    return '{t, op, v1, v2, t1, t2, res};
  endfunction

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] exp_v);
    checks++;
    if (actual !== exp_v) begin
      errors++;
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, actual, exp_v);
    end
  endtask

  task automatic next_cycle();
    @(posedge rst);
    #drive_dly;
  endtask

  task automatic dispatch(input row_t row);
    while (full || pending[row.target]) begin
      next_cycle();
    end
    disp_target = row.target;
    disp_op     = alu_pkg::alu_op_e'(row.op);
    disp_val1   = row.val1;
    disp_val2   = row.val2;
    disp_tag1   = row.tag1;
    disp_tag2   = row.tag2;
    exp_value[row.target] = row.result;
    pending[row.target]   = 1'b1;
    next_cycle();
    disp_target = alu_pkg::tag_invalid;
  endtask

  task automatic wait_drain();
    while (pending != '0) begin
      next_cycle();
    end
  endtask

  task automatic report_test(input string name, input int mark);
    $display("test %-14s %0d error(s)", name, errors - mark);
  endtask

  // ======================================================================
  // CDB monitor, timeout and random ready
  // ======================================================================

  always @(negedge rst) begin
    if (arst_n && cdb_valid && cdb_ready) begin  // Completes on the next rising edge.
      bcast_count++;
      if (!pending[cdb_tag]) begin
        errors++;
        $display("Error: broadcast of tag %0d with no instruction in flight", cdb_tag);
      end else begin
        check($sformatf("cdb_value tag %0d", cdb_tag), cdb_value, exp_value[cdb_tag]);
        pending[cdb_tag] = 1'b0;
      end
    end
  end

  always @(posedge rst) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Simulation FAILED");
      $finish;
    end
  end

  always @(posedge rst) begin
    if (random_ready) begin
      #drive_dly;
      cdb_ready = lfsr_bit();
    end
  end

  // ======================================================================
  // Tests
  // ======================================================================

  initial begin
    arst_n        = 1'b0;
    disp_target   = alu_pkg::tag_invalid;
    disp_op       = alu_pkg::op_add;
    disp_val1     = '0;
    disp_val2     = '0;
    disp_tag1     = alu_pkg::tag_invalid;
    disp_tag2     = alu_pkg::tag_invalid;
    ext_cdb_valid = 1'b0;
    ext_cdb_tag   = alu_pkg::tag_invalid;
    ext_cdb_value = '0;
    cdb_ready     = 1'b1;
    random_ready  = 1'b0;
    pending       = '0;
    repeat (reset_cycles) @(posedge rst);
    #drive_dly;
    arst_n = 1'b1;

    err_mark   = errors;
    bcast_mark = bcast_count;
    check("full", 32'(full), 32'd0);
    check("cdb_valid", 32'(cdb_valid), 32'd0);
    repeat (10) next_cycle();
    check("broadcast count", 32'(bcast_count), 32'(bcast_mark));
    report_test("reset", err_mark);

    err_mark = errors;
    for (int i = 0; i < 17; i++) begin
      dispatch(dir_rows[i]);
    end
    wait_drain();
    report_test("operations", err_mark);

    // Operand 2 waits on tag 9 from outside.
    err_mark = errors;
    dispatch(make_row(4'd3, alu_pkg::op_add, 32'h64, 32'hdead0000, 4'd0, 4'd9, 32'hb4));
    repeat (6) next_cycle();
    check("tag 3 waiting", 32'(pending[3]), 32'd1);
    ext_cdb_valid = 1'b1;
    ext_cdb_tag   = 4'd9;
    ext_cdb_value = 32'h50;
    next_cycle();
    ext_cdb_valid = 1'b0;
    wait_drain();
    report_test("ext wake-up", err_mark);

    err_mark = errors;
    dispatch(make_row(4'd4, alu_pkg::op_add, 32'd10, 32'd20, 4'd0, 4'd0, 32'h1e));
    dispatch(make_row(4'd5, alu_pkg::op_sub, 32'h0, 32'd5, 4'd4, 4'd0, 32'h19));
    wait_drain();
    cdb_ready = 1'b0;  // Hold tag 6 in done to line up the bypass.
    dispatch(make_row(4'd6, alu_pkg::op_xor, 32'h0f, 32'hff, 4'd0, 4'd0, 32'hf0));
    while (!(cdb_valid && cdb_tag == 4'd6)) begin
      next_cycle();
    end
    cdb_ready = 1'b1;
    dispatch(make_row(4'd7, alu_pkg::op_and, 32'hffffffff, 32'h3c, 4'd6, 4'd0, 32'h30));
    wait_drain();
    report_test("forwarding", err_mark);

    err_mark   = errors;
    bcast_mark = bcast_count;
    cdb_ready  = 1'b0;
    for (int k = 0; k < rs_depth + 1; k++) begin
      check("full", 32'(full), 32'd0);
      r = make_row(alu_pkg::tag_t'(k + 1), alu_pkg::op_add, 32'(k) << 8, 32'(k + 1),
                   4'd0, 4'd0, '0);
      r.result = model_result(r.op, r.val1, r.val2);
      dispatch(r);
    end
    check("full", 32'(full), 32'd1);
    hold_tag = alu_pkg::tag_t'(1);  // First dispatch sits in done.
    hold_val = exp_value[1];
    repeat (6) begin
      next_cycle();
      check("cdb_valid", 32'(cdb_valid), 32'd1);
      check("cdb_tag", 32'(cdb_tag), 32'(hold_tag));
      check("cdb_value", cdb_value, hold_val);
    end
    cdb_ready = 1'b1;
    wait_drain();
    check("broadcast count", 32'(bcast_count - bcast_mark), 32'(rs_depth + 1));
    report_test("back-pressure", err_mark);

    err_mark = errors;
    for (int k = 0; k < rand_count; k++) begin
      rand_rows[k].target = alu_pkg::tag_t'(k % 15 + 1);
      rand_rows[k].op     = 4'(take_bits(4));
      rand_rows[k].val1   = take_bits(32);
      rand_rows[k].val2   = take_bits(32);
      rand_rows[k].tag1   = alu_pkg::tag_invalid;
      rand_rows[k].tag2   = alu_pkg::tag_invalid;
      rand_rows[k].result = model_result(rand_rows[k].op, rand_rows[k].val1,
                                         rand_rows[k].val2);
    end
    random_ready = 1'b1;
    for (int k = 0; k < rand_count; k++) begin
      dispatch(rand_rows[k]);
    end
    wait_drain();
    random_ready = 1'b0;
    next_cycle();
    cdb_ready = 1'b1;
    report_test("random", err_mark);

    $display("checks: %0d, errors: %0d, broadcasts: %0d", checks, errors, bcast_count);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- verilog/alu_cluster.sv
`timescale 1ns/1ns

module alu_cluster #(
  parameter int rs_depth = 4
) (
  input  logic             rst,
  input  logic             arst_n,

  input  alu_pkg::tag_t    disp_target,
  input  alu_pkg::alu_op_e disp_op,
  input  alu_pkg::data_t   disp_val1,
  input  alu_pkg::data_t   disp_val2,
  input  alu_pkg::tag_t    disp_tag1,
  input  alu_pkg::tag_t    disp_tag2,
  output logic             full,

  input  logic             ext_cdb_valid,
  input  alu_pkg::tag_t    ext_cdb_tag,
  input  alu_pkg::data_t   ext_cdb_value,

  output logic             cdb_valid,
  output alu_pkg::tag_t    cdb_tag,
  output alu_pkg::data_t   cdb_value,
  input  logic             cdb_ready
);

  alu_dispatch_if disp_bus ();
  alu_issue_if    issue_bus ();

  logic load;
  logic shift_step;
  logic shift_zero;

  assign disp_bus.target = disp_target;
  assign disp_bus.op     = disp_op;
  assign disp_bus.val1   = disp_val1;
  assign disp_bus.val2   = disp_val2;
  assign disp_bus.tag1   = disp_tag1;
  assign disp_bus.tag2   = disp_tag2;

  alu_rs_station #(
    .rs_depth (rs_depth)
  ) i_rs_station (
    .rst           (rst),
    .arst_n        (arst_n),
    .disp          (disp_bus.dst),
    .full          (full),
    .issue         (issue_bus.rs),
    .ext_cdb_valid (ext_cdb_valid),
    .ext_cdb_tag   (ext_cdb_tag),
    .ext_cdb_value (ext_cdb_value),
    .own_cdb_fire  (cdb_valid && cdb_ready),  // Own result completes.
    .own_cdb_tag   (cdb_tag),
    .own_cdb_value (cdb_value)
  );

  alu_exec_fsm i_exec_fsm (
    .rst        (rst),
    .arst_n     (arst_n),
    .issue      (issue_bus.fsm),
    .shift_zero (shift_zero),
    .cdb_ready  (cdb_ready),
    .load       (load),
    .shift_step (shift_step),
    .cdb_valid  (cdb_valid)
  );

  alu_shift_counter i_shift_counter (
    .rst    (rst),
    .arst_n (arst_n),
    .load   (load),
    .amount (issue_bus.src1[4:0]),  // Shift amount.
    .step   (shift_step),
    .zero   (shift_zero)
  );

  alu_datapath i_datapath (
    .rst        (rst),
    .arst_n     (arst_n),
    .issue      (issue_bus.dp),
    .load       (load),
    .shift_step (shift_step),
    .result_tag (cdb_tag),
    .result     (cdb_value)
  );

endmodule

//--- verilog/alu_datapath.sv
`timescale 1ns/1ns

module alu_datapath (
  input  logic           rst,
  input  logic           arst_n,
  alu_issue_if.dp        issue,
  input  logic           load,
  input  logic           shift_step,
  output alu_pkg::tag_t  result_tag,
  output alu_pkg::data_t result
);

  alu_pkg::alu_op_e op_q;
  alu_pkg::data_t   calc;

  // ======================================================================
  // Single-cycle operations
  // ======================================================================

  function automatic alu_pkg::data_t alu_calc(
    input alu_pkg::alu_op_e op,
    input alu_pkg::data_t   a,
    input alu_pkg::data_t   b
  );
    alu_pkg::data_t r;
    r = '0;
    case (op)
      alu_pkg::op_add,
      alu_pkg::op_addu: r = a + b;
      alu_pkg::op_sub,
      alu_pkg::op_subu: r = a - b;
      alu_pkg::op_and:  r = a & b;
      alu_pkg::op_or:   r = a | b;
      alu_pkg::op_nor:  r = ~(a | b);
      alu_pkg::op_xor:  r = a ^ b;
      alu_pkg::op_seq:  r[0] = (a == b);
      alu_pkg::op_slt:  r[0] = ($signed(a) < $signed(b));
      alu_pkg::op_sltu: r[0] = (a < b);
      default:          r = '0;  // Unused codes.
    endcase
    return r;
  endfunction

  // One bit of a shift or rotate.
  function automatic alu_pkg::data_t shift_one(
    input alu_pkg::alu_op_e op,
    input alu_pkg::data_t   r
  );
    alu_pkg::data_t s;
    s = r;
    case (op)
      alu_pkg::op_sll: s = {r[alu_pkg::data_w-2:0], 1'b0};
      alu_pkg::op_srl: s = {1'b0, r[alu_pkg::data_w-1:1]};
      alu_pkg::op_sra: s = {r[alu_pkg::data_w-1], r[alu_pkg::data_w-1:1]};
      alu_pkg::op_ror: s = {r[0], r[alu_pkg::data_w-1:1]};
      default:         s = r;
    endcase
    return s;
  endfunction

  // Shifts start from operand 2 and move from there.
  assign calc = alu_pkg::is_shift_op(issue.op) ? issue.src2 :
                alu_calc(issue.op, issue.src1, issue.src2);

  // ======================================================================
  // Registers
  // ======================================================================

  always_ff @(posedge rst or negedge arst_n) begin
    if (!arst_n) begin
      result_tag <= alu_pkg::tag_invalid;
      op_q       <= alu_pkg::op_add;
      result     <= '0;
    end else if (load) begin
      result_tag <= issue.target;
      op_q       <= issue.op;
      result     <= calc;
    end else if (shift_step) begin
      result     <= shift_one(op_q, result);
    end
  end

endmodule

//--- verilog/alu_shift_counter.sv
`timescale 1ns/1ns

module alu_shift_counter (
  input  logic       rst,
  input  logic       arst_n,
  input  logic       load,
  input  logic [4:0] amount,
  input  logic       step,
  output logic       zero
);

  // Steps left after the one in the current cycle.
  logic [4:0] cnt;

  always_ff @(posedge rst or negedge arst_n) begin
    if (!arst_n) begin
      cnt <= '0;
    end else if (load) begin
      cnt <= (amount == 5'd0) ? 5'd0 : amount - 5'd1;
    end else if (step && cnt != 5'd0) begin
      cnt <= cnt - 5'd1;
    end
  end

  // During load the amount itself decides whether a shift phase is needed.
  assign zero = load ? (amount == 5'd0) : (cnt == 5'd0);

endmodule

//--- verilog/alu_exec_fsm.sv
`timescale 1ns/1ns

module alu_exec_fsm (
  input  logic     rst,
  input  logic     arst_n,
  alu_issue_if.fsm issue,
  input  logic     shift_zero,
  input  logic     cdb_ready,
  output logic     load,
  output logic     shift_step,
  output logic     cdb_valid
);

  typedef enum logic [1:0] {
    st_idle,
    st_shift,
    st_done
  } state_e;

  state_e state;
  state_e state_nxt;

  // ======================================================================
  // State register
  // ======================================================================

  always_ff @(posedge rst or negedge arst_n) begin
    if (!arst_n) begin
      state <= st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  // ======================================================================
  // Next state
  // ======================================================================

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: begin
        if (issue.valid) begin
          // Amount 0 skips the shift phase.
          if (alu_pkg::is_shift_op(issue.op) && !shift_zero) begin
            state_nxt = st_shift;
          end else begin
            state_nxt = st_done;
          end
        end
      end
      st_shift: begin
        if (shift_zero) begin  // Last step this cycle.
          state_nxt = st_done;
        end
      end
      st_done: begin
        if (cdb_ready) begin
          state_nxt = st_idle;
        end
      end
      default: state_nxt = st_idle;
    endcase
  end

  assign issue.take = (state == st_idle);
  assign load       = (state == st_idle) && issue.valid;
  assign shift_step = (state == st_shift);
  assign cdb_valid  = (state == st_done);  // Held until the broadcast completes.

endmodule

//--- verilog/alu_rs_station.sv
`timescale 1ns/1ns

module alu_rs_station #(
  parameter int rs_depth = 4
) (
  input  logic           rst,
  input  logic           arst_n,
  alu_dispatch_if.dst    disp,
  output logic           full,
  alu_issue_if.rs        issue,
  input  logic           ext_cdb_valid,
  input  alu_pkg::tag_t  ext_cdb_tag,
  input  alu_pkg::data_t ext_cdb_value,
  input  logic           own_cdb_fire,
  input  alu_pkg::tag_t  own_cdb_tag,
  input  alu_pkg::data_t own_cdb_value
);

  localparam int idx_w = $clog2(rs_depth);

  typedef struct packed {
    alu_pkg::tag_t  tag;
    alu_pkg::data_t val;
  } opnd_t;

  logic [rs_depth-1:0] ent_valid;
  alu_pkg::tag_t       ent_target [rs_depth];
  alu_pkg::alu_op_e    ent_op     [rs_depth];
  opnd_t               ent_src1   [rs_depth];
  opnd_t               ent_src2   [rs_depth];

  logic [rs_depth-1:0] ready;
  logic [idx_w-1:0]    sel_idx;
  logic [idx_w-1:0]    free_idx;
  logic                accept;
  logic                fire;
  opnd_t               disp_src1;
  opnd_t               disp_src2;

  // Capture a broadcast value for an operand still waiting on its tag.
  function automatic opnd_t snoop(opnd_t o);
    opnd_t r;
    r = o;
    if (o.tag != alu_pkg::tag_invalid) begin
      if (ext_cdb_valid && ext_cdb_tag == o.tag) begin
        r.tag = alu_pkg::tag_invalid;
        r.val = ext_cdb_value;
      end else if (own_cdb_fire && own_cdb_tag == o.tag) begin
        r.tag = alu_pkg::tag_invalid;
        r.val = own_cdb_value;
      end
    end
    return r;
  endfunction

  // ======================================================================
  // Selection
  // ======================================================================

  always_comb begin
    for (int i = 0; i < rs_depth; i++) begin
      ready[i] = ent_valid[i] &&
                 ent_src1[i].tag == alu_pkg::tag_invalid &&
                 ent_src2[i].tag == alu_pkg::tag_invalid;
    end
  end

  always_comb begin
    free_idx = '0;
    sel_idx  = '0;
    for (int i = rs_depth - 1; i >= 0; i--) begin  // Lowest index wins.
      if (!ent_valid[i]) begin
        free_idx = idx_w'(i);
      end
      if (ready[i]) begin
        sel_idx = idx_w'(i);
      end
    end
  end

  assign full   = &ent_valid;
  assign accept = disp.target != alu_pkg::tag_invalid && !full;
  assign fire   = issue.valid && issue.take;

  assign disp_src1 = snoop(opnd_t'{tag: disp.tag1, val: disp.val1});  // Same-cycle bypass.
  assign disp_src2 = snoop(opnd_t'{tag: disp.tag2, val: disp.val2});

  assign issue.valid  = |ready;
  assign issue.target = ent_target[sel_idx];
  assign issue.op     = ent_op[sel_idx];
  assign issue.src1   = ent_src1[sel_idx].val;
  assign issue.src2   = ent_src2[sel_idx].val;

  // ======================================================================
  // Entry storage
  // ======================================================================

  always_ff @(posedge rst or negedge arst_n) begin
    if (!arst_n) begin
      ent_valid <= '0;
    end else begin
      if (fire) begin
        ent_valid[sel_idx] <= 1'b0;
      end
      if (accept) begin
        ent_valid[free_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge rst) begin
    for (int i = 0; i < rs_depth; i++) begin
      if (ent_valid[i]) begin
        ent_src1[i] <= snoop(ent_src1[i]);  // Wake-up.
        ent_src2[i] <= snoop(ent_src2[i]);
      end
    end
    if (accept) begin
      ent_target[free_idx] <= disp.target;
      ent_op[free_idx]     <= disp.op;
      ent_src1[free_idx]   <= disp_src1;
      ent_src2[free_idx]   <= disp_src2;
    end
  end

endmodule

//--- verilog/alu_ifs.sv
`timescale 1ns/1ns

// Dispatch slot into the reservation station.
interface alu_dispatch_if;
  alu_pkg::tag_t    target;  // tag_invalid means no instruction.
  alu_pkg::alu_op_e op;
  alu_pkg::data_t   val1;
  alu_pkg::data_t   val2;
  alu_pkg::tag_t    tag1;
  alu_pkg::tag_t    tag2;

  modport src (output target, op, val1, val2, tag1, tag2);
  modport dst (input  target, op, val1, val2, tag1, tag2);
endinterface

// Issue path from the station to the execution unit.
interface alu_issue_if;
  logic             valid;
  logic             take;
  alu_pkg::tag_t    target;
  alu_pkg::alu_op_e op;
  alu_pkg::data_t   src1;
  alu_pkg::data_t   src2;

  modport rs  (output valid, target, op, src1, src2, input take);
  modport fsm (input  valid, op, output take);
  modport dp  (input  target, op, src1, src2);
endinterface

//--- verilog/alu_pkg.sv
package alu_pkg;

  // ======================================================================
  // Widths and tags
  // ======================================================================

  localparam int data_w = 32;  // Operand and result width.
  localparam int tag_w  = 4;   // Instruction tag width.

  typedef logic [data_w-1:0] data_t;
  typedef logic [tag_w-1:0]  tag_t;

  // No tag. On an operand the value is present, on a target no instruction.
  localparam tag_t tag_invalid = '0;

  // ======================================================================
  // ALU operation encoding
  // ======================================================================

  typedef enum logic [3:0] {
    op_add  = 4'd0,
    op_addu = 4'd1,
    op_sub  = 4'd2,
    op_subu = 4'd3,
    op_and  = 4'd4,
    op_or   = 4'd5,
    op_nor  = 4'd6,
    op_xor  = 4'd7,
    op_sll  = 4'd8,   // Shifts act on operand 2 by operand 1 [4:0].
    op_srl  = 4'd9,
    op_sra  = 4'd10,
    op_ror  = 4'd11,
    op_seq  = 4'd12,
    op_slt  = 4'd13,  // Signed.
    op_sltu = 4'd14
  } alu_op_e;

  // Operations that run bit-serially through the shifter.
  function automatic logic is_shift_op(alu_op_e op);
    return op inside {op_sll, op_srl, op_sra, op_ror};
  endfunction

endpackage
